// File: project.f
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_cmd_ctrl.sv
design/uart_bridge.sv
dv/uart_bridge_assertions.sv
dv/uart_bridge_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the UART bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module uart_bridge_tb -o sim_uart_bridge
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_uart_bridge +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// File: dv/uart_bridge_tb.sv
module uart_bridge_tb;
  import uart_pkg::*;

  localparam int BIT_CYCLES        = 8;
  localparam int GAP_BITS          = 2;
  localparam int RESP_TIMEOUT_BITS = 32;
  localparam int WAIT_LIMIT        = 80 * BIT_CYCLES;
  localparam int NUM_ROWS          = 6;

  typedef enum logic [1:0] {
    RESP_GOOD,
    RESP_BAD_PARITY,
    RESP_SILENT
  } resp_mode_e;

  typedef struct packed {
    logic [CMD_WIDTH-1:0]       cmd;
    resp_mode_e                 mode;
    logic [FRAME_DATA_BITS-1:0] resp;
    logic                       extra_vld;
    logic [FRAME_DATA_BITS-1:0] exp_data;
    logic                       exp_err;
  } row_t;

  logic                       clk;
  logic                       rst_n;
  logic [CMD_WIDTH-1:0]       cmd_in;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic [FRAME_DATA_BITS-1:0] read_data;
  logic                       read_rdy;
  logic                       read_err;
  logic                       tx;
  logic                       rx;

  row_t                       rows [NUM_ROWS];
  int                         seed = 65285;
  int                         mismatches = 0;
  int                         timeouts = 0;
  resp_mode_e                 cur_mode = RESP_SILENT;
  logic [FRAME_DATA_BITS-1:0] cur_resp = '0;
  logic                       dev_busy = 1'b0;
  logic [FRAME_DATA_BITS-1:0] frame_bytes [$];
  logic                       frame_pars [$];
  logic                       frame_stops [$];

  uart_bridge #(
    .BIT_CYCLES        (BIT_CYCLES),
    .GAP_BITS          (GAP_BITS),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .tx        (tx),
    .rx        (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Parity bit that makes the number of ones in the frame even
  function automatic logic even_parity(input logic [FRAME_DATA_BITS-1:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < FRAME_DATA_BITS; i++)
      ones += int'(b[i]);
    return (ones % 2) == 1;
  endfunction

  task automatic check_byte(input string what, input logic [FRAME_DATA_BITS-1:0] got,
                            input logic [FRAME_DATA_BITS-1:0] exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_op(input string what, input cmd_op_e got, input cmd_op_e exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
    begin
      mismatches++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(input int idx, input logic [FRAME_DATA_BITS-1:0] exp,
                             input string what);
    if (idx < frame_bytes.size())
    begin
      check_byte(what, frame_bytes[idx], exp);
      check_flag({what, " parity"}, frame_pars[idx], even_parity(exp));
      check_flag({what, " stop bit"}, frame_stops[idx], 1'b1);
    end
  endtask

  task automatic wait_cmd_rdy(input string what);
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
    begin
      timeouts++;
      $display("Timed out waiting for cmd_rdy during %s", what);
    end
  endtask

  task automatic wait_read(output logic [FRAME_DATA_BITS-1:0] data, output logic err,
                           output logic rdy);
    int n;
    n = 0;
    @(negedge clk);
    while (read_rdy !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (read_rdy !== 1'b1)
    begin
      timeouts++;
      $display("Timed out waiting for read_rdy");
    end
    data = read_data;
    err  = read_err;
    rdy  = cmd_rdy;
  endtask

  task automatic wait_frames(input int count);
    int n;
    n = 0;
    while (frame_bytes.size() < count && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (frame_bytes.size() < count)
    begin
      timeouts++;
      $display("Timed out waiting for a frame on tx, %0d seen", frame_bytes.size());
    end
  endtask

  task automatic wait_device_idle();
    int n;
    n = 0;
    while (dev_busy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (dev_busy)
    begin
      timeouts++;
      $display("Timed out waiting for the serial device model to go idle");
    end
  endtask

  task automatic receive_frame(output logic [FRAME_DATA_BITS-1:0] b, output logic par,
                               output logic stop);
    repeat (BIT_CYCLES / 2) @(negedge clk);
    for (int i = 0; i < FRAME_DATA_BITS; i++)
    begin
      repeat (BIT_CYCLES) @(negedge clk);
      b[i] = tx;
    end
    repeat (BIT_CYCLES) @(negedge clk);
    par = tx;
    repeat (BIT_CYCLES) @(negedge clk);
    stop = tx;
  endtask

  task automatic send_frame(input logic [FRAME_DATA_BITS-1:0] b, input logic bad_parity);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, even_parity(b) ^ bad_parity, b, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (BIT_CYCLES) @(posedge clk);
      #1;
    end
  endtask

  // Remote register device: decodes every frame and answers read address frames
  initial
  begin : device_model
    logic [FRAME_DATA_BITS-1:0] b;
    logic                       par;
    logic                       stop;
    rx = 1'b1;
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx === 1'b0)
      begin
        dev_busy = 1'b1;
        receive_frame(b, par, stop);
        frame_bytes.push_back(b);
        frame_pars.push_back(par);
        frame_stops.push_back(stop);
        if (cmd_op_e'(b[7]) == OP_READ && cur_mode != RESP_SILENT)
        begin
          // Rest of the stop bit, then three idle bit times
          repeat (BIT_CYCLES / 2 + 3 * BIT_CYCLES) @(negedge clk);
          send_frame(cur_resp, cur_mode == RESP_BAD_PARITY);
        end
        dev_busy = 1'b0;
      end
    end
  end

  task automatic build_table();
    int rnd;
    rows[0] = '{16'h92A5, RESP_GOOD,       8'h00, 1'b1, 8'h00, 1'b0};
    rows[1] = '{16'h1200, RESP_GOOD,       8'h00, 1'b0, 8'h00, 1'b0};
    rows[2] = '{16'h35FF, RESP_BAD_PARITY, 8'h00, 1'b0, 8'h00, 1'b0};
    rows[3] = '{16'h7F00, RESP_SILENT,     8'h00, 1'b1, 8'h00, 1'b0};
    rows[4] = '{16'hFF3C, RESP_GOOD,       8'h00, 1'b0, 8'h00, 1'b0};
    rows[5] = '{16'h0000, RESP_GOOD,       8'h00, 1'b1, 8'h00, 1'b0};
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      rnd = $random(seed);
      rows[i].resp = rnd[7:0];
      // A silent device ends in a timeout with zero data, a bad reply is still returned
      rows[i].exp_data = (rows[i].mode == RESP_SILENT) ? '0 : rnd[7:0];
      rows[i].exp_err  = (rows[i].mode != RESP_GOOD);
    end
  endtask

  task automatic issue_command(input row_t row);
    cur_mode = row.mode;
    cur_resp = row.resp;
    wait_cmd_rdy("command issue");
    @(posedge clk);
    #1;
    cmd_in  = row.cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    check_flag("cmd_rdy after acceptance", cmd_rdy, 1'b0);
    if (row.extra_vld)
    begin
      // Busy bridge must ignore this one
      repeat (3) @(posedge clk);
      #1;
      cmd_in  = ~row.cmd;
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
    end
  endtask

  initial
  begin : main_flow
    int                         base;
    int                         assert_fails;
    logic [FRAME_DATA_BITS-1:0] got_data;
    logic                       got_err;
    logic                       got_rdy;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    build_table();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("tx after reset", tx, 1'b1);
    check_flag("cmd_rdy after reset", cmd_rdy, 1'b1);
    check_flag("read_rdy after reset", read_rdy, 1'b0);
    check_flag("read_err after reset", read_err, 1'b0);
    check_byte("read_data after reset", read_data, 8'h00);
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      base = frame_bytes.size();
      issue_command(rows[i]);
      if (cmd_op_e'(rows[i].cmd[15]) == OP_WRITE)
      begin
        wait_cmd_rdy("write");
        wait_frames(base + 2);
        check_frame(base, rows[i].cmd[15:8], "write address frame");
        check_frame(base + 1, rows[i].cmd[7:0], "write data frame");
      end
      else
      begin
        wait_read(got_data, got_err, got_rdy);
        check_byte("read_data", got_data, rows[i].exp_data);
        check_flag("read_err", got_err, rows[i].exp_err);
        check_flag("cmd_rdy with read_rdy", got_rdy, 1'b1);
        wait_frames(base + 1);
        check_frame(base, rows[i].cmd[15:8], "read address frame");
      end
      if (base < frame_bytes.size())
      begin
        check_op("address frame opcode", cmd_op_e'(frame_bytes[base][7]),
                 cmd_op_e'(rows[i].cmd[15]));
      end
      wait_device_idle();
      check_count("frames for the command", frame_bytes.size() - base,
                  (cmd_op_e'(rows[i].cmd[15]) == OP_WRITE) ? 2 : 1);
    end
    assert_fails = dut_i.assertions_i.pulse_fails + dut_i.assertions_i.idle_fails
                 + dut_i.assertions_i.hold_fails;
    $display("Value mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             mismatches, timeouts, assert_fails);
    if (mismatches == 0 && timeouts == 0 && assert_fails == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: dv/uart_bridge_assertions.sv
module uart_bridge_assertions #(
  parameter int BIT_CYCLES = 434
) (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic read_rdy,
  input logic tx
);
  import uart_pkg::*;

  localparam int FRAME_CYCLES = FRAME_BITS * BIT_CYCLES;

  int since_accept;
  int pulse_fails = 0;
  int idle_fails = 0;
  int hold_fails = 0;

  // Counts cycles after an accepted command and drops to zero after one frame time
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      since_accept <= 0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      since_accept <= 1;
    end
    else if (since_accept != 0 && since_accept < FRAME_CYCLES)
    begin
      since_accept <= since_accept + 1;
    end
    else
    begin
      since_accept <= 0;
    end
  end

  read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else
    begin
      pulse_fails++;
      $error("read_rdy stayed high for more than one cycle");
    end

  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else
    begin
      idle_fails++;
      $error("tx is low while cmd_rdy is high");
    end

  rdy_held_low: assert property (@(posedge clk) disable iff (!rst_n)
                                 since_accept != 0 |-> !cmd_rdy)
    else
    begin
      hold_fails++;
      $error("cmd_rdy rose within one frame of command acceptance");
    end

endmodule

bind uart_bridge uart_bridge_assertions #(
  .BIT_CYCLES (BIT_CYCLES)
) assertions_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy),
  .tx       (tx)
);

// File: design/uart_bridge.sv
module uart_bridge #(
  parameter int BIT_CYCLES        = 434,
  parameter int GAP_BITS          = 2,
  parameter int RESP_TIMEOUT_BITS = 32
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [uart_pkg::CMD_WIDTH-1:0]       cmd_in,
  input  logic                                 cmd_vld,
  output logic                                 cmd_rdy,
  output logic [uart_pkg::FRAME_DATA_BITS-1:0] read_data,
  output logic                                 read_rdy,
  output logic                                 read_err,
  output logic                                 tx,
  input  logic                                 rx
);
  import uart_pkg::*;

  logic                       tx_start;
  logic [FRAME_DATA_BITS-1:0] tx_byte;
  logic                       tx_busy;
  logic                       tx_done;
  logic                       rx_vld;
  logic                       rx_err;
  logic                       rx_active;
  logic [FRAME_DATA_BITS-1:0] rx_byte;

  uart_rx #(
    .BIT_CYCLES (BIT_CYCLES)
  ) rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_vld    (rx_vld),
    .rx_err    (rx_err),
    .rx_active (rx_active),
    .rx_byte   (rx_byte)
  );

  uart_cmd_ctrl #(
    .BIT_CYCLES        (BIT_CYCLES),
    .GAP_BITS          (GAP_BITS),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done),
    .rx_vld    (rx_vld),
    .rx_err    (rx_err),
    .rx_active (rx_active),
    .rx_byte   (rx_byte),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx #(
    .BIT_CYCLES (BIT_CYCLES)
  ) tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done),
    .tx       (tx)
  );

endmodule

// File: design/uart_cmd_ctrl.sv
module uart_cmd_ctrl #(
  parameter int BIT_CYCLES        = 434,
  parameter int GAP_BITS          = 2,
  parameter int RESP_TIMEOUT_BITS = 32
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [uart_pkg::CMD_WIDTH-1:0]       cmd_in,
  input  logic                                 cmd_vld,
  output logic                                 cmd_rdy,
  output logic                                 tx_start,
  output logic [uart_pkg::FRAME_DATA_BITS-1:0] tx_byte,
  input  logic                                 tx_busy,
  input  logic                                 tx_done,
  input  logic                                 rx_vld,
  input  logic                                 rx_err,
  input  logic                                 rx_active,
  input  logic [uart_pkg::FRAME_DATA_BITS-1:0] rx_byte,
  output logic [uart_pkg::FRAME_DATA_BITS-1:0] read_data,
  output logic                                 read_rdy,
  output logic                                 read_err
);
  import uart_pkg::*;

  localparam int CNT_W    = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
  localparam int MAX_BITS = (GAP_BITS > RESP_TIMEOUT_BITS) ? GAP_BITS : RESP_TIMEOUT_BITS;
  localparam int BIT_W    = $clog2(MAX_BITS + 1);

  ctrl_state_e          state;
  cmd_op_e              op;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic [CNT_W-1:0]     cyc_cnt;
  logic [BIT_W-1:0]     bit_cnt;
  logic                 bit_tick;
  logic                 accept;

  assign cmd_rdy  = (state == CTRL_IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign op       = cmd_op_e'(cmd_q[CMD_WIDTH-1]);
  assign bit_tick = (cyc_cnt == CNT_W'(BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= CTRL_IDLE;
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
      read_data <= '0;
      cyc_cnt   <= '0;
      bit_cnt   <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        CTRL_IDLE:
        begin
          // The transmitter is always idle here, so the address can go out now
          if (accept && !tx_busy)
          begin
            tx_start <= 1'b1;
            state    <= CTRL_SEND_ADDR;
          end
        end
        CTRL_SEND_ADDR:
        begin
          if (tx_done)
          begin
            cyc_cnt <= '0;
            bit_cnt <= '0;
            state   <= (op == OP_WRITE) ? CTRL_GAP : CTRL_WAIT_RESP;
          end
        end
        CTRL_GAP:
        begin
          if (bit_tick)
          begin
            cyc_cnt <= '0;
            if (bit_cnt == BIT_W'(GAP_BITS - 1))
            begin
              tx_start <= 1'b1;
              state    <= CTRL_SEND_DATA;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        CTRL_SEND_DATA:
        begin
          if (tx_done)
          begin
            state <= CTRL_IDLE;
          end
        end
        CTRL_WAIT_RESP:
        begin
          if (rx_vld)
          begin
            read_data <= rx_byte;
            read_err  <= rx_err;
            read_rdy  <= 1'b1;
            state     <= CTRL_IDLE;
          end
          else if (!rx_active)
          begin
            // Timeout only runs while no response frame is coming in
            if (bit_tick)
            begin
              cyc_cnt <= '0;
              if (bit_cnt == BIT_W'(RESP_TIMEOUT_BITS - 1))
              begin
                read_data <= '0;
                read_err  <= 1'b1;
                read_rdy  <= 1'b1;
                state     <= CTRL_IDLE;
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
            else
            begin
              cyc_cnt <= cyc_cnt + 1'b1;
            end
          end
        end
        default:
        begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept && !tx_busy)
    begin
      // Address frame is the opcode bit followed by the register address
      cmd_q   <= cmd_in;
      tx_byte <= cmd_in[CMD_WIDTH-1 -: FRAME_DATA_BITS];
    end
    else if (state == CTRL_GAP)
    begin
      tx_byte <= cmd_q[FRAME_DATA_BITS-1:0];
    end
  end

endmodule

// File: design/uart_rx.sv
module uart_rx #(
  parameter int BIT_CYCLES = 434
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 rx,
  output logic                                 rx_vld,
  output logic                                 rx_err,
  output logic                                 rx_active,
  output logic [uart_pkg::FRAME_DATA_BITS-1:0] rx_byte
);
  import uart_pkg::*;

  localparam int CNT_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
  localparam int HALF  = BIT_CYCLES / 2;

  logic                       rx_meta;
  logic                       rx_sync;
  logic [CNT_W-1:0]           cyc_cnt;
  logic [3:0]                 bit_idx;
  logic                       sample;
  logic [FRAME_DATA_BITS-1:0] shift_q;
  logic                       par_q;

  // The start bit is checked half a bit in, every later bit one full bit on
  assign sample = (bit_idx == 4'd0) ? (cyc_cnt == CNT_W'(HALF - 1))
                                    : (cyc_cnt == CNT_W'(BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_active <= 1'b0;
      rx_vld    <= 1'b0;
      rx_err    <= 1'b0;
      cyc_cnt   <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_vld  <= 1'b0;
      if (!rx_active)
      begin
        cyc_cnt <= '0;
        bit_idx <= '0;
        if (!rx_sync)
        begin
          rx_active <= 1'b1;
        end
      end
      else if (sample)
      begin
        cyc_cnt <= '0;
        if (bit_idx == 4'd0 && rx_sync)
        begin
          // Line went back high before mid-bit, treat it as a glitch
          rx_active <= 1'b0;
        end
        else if (bit_idx == 4'(FRAME_BITS - 1))
        begin
          rx_active <= 1'b0;
          rx_vld    <= 1'b1;
          rx_err    <= ((^shift_q) != par_q) || !rx_sync;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_active && sample)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'(FRAME_DATA_BITS))
      begin
        shift_q <= {rx_sync, shift_q[FRAME_DATA_BITS-1:1]};
      end
      if (bit_idx == 4'(FRAME_DATA_BITS + 1))
      begin
        par_q <= rx_sync;
      end
      if (bit_idx == 4'(FRAME_BITS - 1))
      begin
        rx_byte <= shift_q;
      end
    end
  end

endmodule

// File: design/uart_tx.sv
module uart_tx #(
  parameter int BIT_CYCLES = 434
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 tx_start,
  input  logic [uart_pkg::FRAME_DATA_BITS-1:0] tx_byte,
  output logic                                 tx_busy,
  output logic                                 tx_done,
  output logic                                 tx
);
  import uart_pkg::*;

  localparam int CNT_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

  logic [CNT_W-1:0]           cyc_cnt;
  logic [3:0]                 bit_idx;
  logic                       bit_end;
  // Bits still to go out after the start bit: data LSB first, parity, stop
  logic [FRAME_DATA_BITS+1:0] shift_q;

  assign bit_end = (cyc_cnt == CNT_W'(BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
      tx      <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (!tx_busy)
      begin
        if (tx_start)
        begin
          // Start bit goes on the line right away
          tx_busy <= 1'b1;
          tx      <= 1'b0;
          cyc_cnt <= '0;
          bit_idx <= '0;
        end
      end
      else if (bit_end)
      begin
        cyc_cnt <= '0;
        if (bit_idx == 4'(FRAME_BITS - 1))
        begin
          // End of the stop bit, the line is already high
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
          tx      <= shift_q[0];
        end
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
    begin
      // XOR of the data gives the bit that makes the count of ones even
      shift_q <= {1'b1, ^tx_byte, tx_byte};
    end
    else if (tx_busy && bit_end)
    begin
      shift_q <= {1'b1, shift_q[FRAME_DATA_BITS+1:1]};
    end
  end

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

  // Host command width: opcode, 7-bit register address, write data
  localparam int CMD_WIDTH = 16;

  localparam int FRAME_DATA_BITS = 8;

  // Start, data, parity and stop bits of one serial frame
  localparam int FRAME_BITS = FRAME_DATA_BITS + 3;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_SEND_ADDR,
    CTRL_GAP,
    CTRL_SEND_DATA,
    CTRL_WAIT_RESP
  } ctrl_state_e;

  // Taken from the top bit of the command
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

endpackage
